// File: src.f
common/vision_pkg.sv
src/video_timing.sv
src/vision_regs.sv
src/fb_address.sv
tracker/pixel_mask.sv
tracker/center_of_mass.sv
src/video_compose.sv
src/vision_top.sv
tb/vision_props.sv
tb/tb_vision_top.sv

// File: tb/tb_vision_top.sv
`default_nettype none

module tb_vision_top;
    timeunit 1ns;
    timeprecision 1ps;
    import vision_pkg::*;

    localparam int h_active = 32;
    localparam int h_front = 2;
    localparam int h_sync = 4;
    localparam int h_back = 2;
    localparam int v_active = 16;
    localparam int v_front = 1;
    localparam int v_sync = 2;
    localparam int v_back = 1;
    localparam int h_total = h_active + h_front + h_sync + h_back;   // 40
    localparam int v_total = v_active + v_front + v_sync + v_back;   // 20
    localparam int fb_w = 16;
    localparam int fb_h = 8;
    localparam int fb_addr_w = $clog2(fb_w * fb_h);
    localparam int frame_cycles = h_total * v_total;
    localparam int clk_period = 40;
    localparam int n_configs = 9;
    localparam int run_frames = 3 * n_configs + 6;       // 3 per config, com wait, apb errors, margin
    localparam logic [31:0] rng_seed = 32'h8078_e11a;

    logic                   clk_pixel = 1'b0;
    logic                   recent_reset, psel, penable, pwrite;
    logic [apb_addr_w-1:0]  paddr;
    logic [apb_data_w-1:0]  pwdata, prdata;
    logic                   pready, pslverr, fb_valid, hsync, vsync, de, com_valid;
    logic [fb_addr_w-1:0]   fb_addr;
    logic [fb_addr_w-1:0]   fb_addr_q;                   // address taken one cycle ago
    pixel_t                 fb_pixel, pix_out;
    logic [coord_w-1:0]     com_x, com_y;

    pixel_t             fb_mem [fb_w * fb_h];            // external frame buffer contents
    int                 hc, vc;                          // own copy of the screen counters
    logic               check_en;
    logic [chan_w-1:0]  cfg_channel;                     // configuration applied by the tests
    logic [mode_w-1:0]  cfg_mode;
    logic               cfg_scale;
    logic [7:0]         cfg_lower, cfg_upper;
    logic [coord_w-1:0] exp_com_x, exp_com_y;

    vision_top #(
        .H_ACTIVE(h_active), .H_FRONT(h_front), .H_SYNC(h_sync), .H_BACK(h_back),
        .V_ACTIVE(v_active), .V_FRONT(v_front), .V_SYNC(v_sync), .V_BACK(v_back),
        .FB_W(fb_w), .FB_H(fb_h)
    ) i_vision_top (
        .clk_pixel, .recent_reset, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .fb_addr, .fb_valid, .fb_pixel,
        .pix_out, .hsync, .vsync, .de, .com_x, .com_y, .com_valid
    );

    always #(clk_period / 2) clk_pixel = ~clk_pixel;

    // data for the previous cycle's address, like a registered bram read
    always @(negedge clk_pixel) begin
        fb_addr_q <= fb_addr;
        fb_pixel  <= fb_mem[fb_addr_q];
    end

    always @(posedge clk_pixel) begin
        if (recent_reset) begin
            hc <= 0;
            vc <= 0;
        end else if (hc == h_total - 1) begin
            hc <= 0;
            vc <= (vc == v_total - 1) ? 0 : vc + 1;
        end else begin
            hc <= hc + 1;
        end
    end

    function automatic int scaled(int c);
        return cfg_scale ? c / 4 : c;                    // 4x: one fb pixel per 4x4 block
    endfunction

    function automatic logic in_buffer(int ox, int oy);
        return (scaled(ox) < fb_w) && (scaled(oy) < fb_h);
    endfunction

    function automatic pixel_t camera_pixel(int ox, int oy);
        if (!in_buffer(ox, oy)) return '0;
        return fb_mem[scaled(oy) * fb_w + (fb_w - 1 - scaled(ox))];  // mirrored column
    endfunction

    function automatic logic [7:0] channel_value(pixel_t p);
        case (cfg_channel)
            CH_RED:   return p.rgb.red;
            CH_GREEN: return p.rgb.green;
            CH_BLUE:  return p.rgb.blue;
            default:  return 8'h00;                      // code 3 has no channel
        endcase
    endfunction

    function automatic logic is_masked(int ox, int oy);
        logic [7:0] b;
        b = channel_value(camera_pixel(ox, oy));
        return in_buffer(ox, oy) && (b >= cfg_lower) && (b <= cfg_upper);
    endfunction

    // output pixel of an active coordinate under the applied configuration
    function automatic pixel_t expected_pixel(int ox, int oy);
        pixel_t     cam, gray, white;
        logic [7:0] b;
        cam = camera_pixel(ox, oy);
        b = channel_value(cam);
        gray = {b, b, b};
        white = '1;
        case (cfg_mode)
            MODE_CAMERA:  return cam;
            MODE_CHANNEL: return gray;
            MODE_MASK:    return is_masked(ox, oy) ? white : '0;
            default:      return ((ox == exp_com_x) || (oy == exp_com_y)) ? white : cam;
        endcase
    endfunction

    function automatic logic [apb_data_w-1:0] ctrl_word();
        return {{(apb_data_w - 5){1'b0}}, cfg_scale, cfg_mode, cfg_channel};
    endfunction

    function automatic logic [apb_data_w-1:0] thresh_word();
        return {{(apb_data_w - 16){1'b0}}, cfg_upper, cfg_lower};
    endfunction

    task automatic compute_expected_com();
        int sum_x, sum_y, count;
        sum_x = 0;
        sum_y = 0;
        count = 0;
        for (int y = 0; y < v_total; y++) begin
            for (int x = 0; x < h_total; x++) begin   // blanking counts too
                if (is_masked(x, y)) begin
                    sum_x += x;
                    sum_y += y;
                    count++;
                end
            end
        end
        if (count != 0) begin                        // empty frame keeps the old center
            exp_com_x = coord_w'(sum_x / count);
            exp_com_y = coord_w'(sum_y / count);
        end
    endtask

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic compare_pixel(input pixel_t got, input pixel_t exp,
                                 input int ox, input int oy);
        if (got !== exp) begin
            $display("[FAIL] %0t: pix_out %h at (%0d,%0d), expected %h",
                     $time, got, ox, oy, exp);
            abort_run();
        end
    endtask

    task automatic inspect_timing(input logic ghs, input logic gvs, input logic gde,
                                  input logic ehs, input logic evs, input logic ede,
                                  input int ox, input int oy);
        if ((ghs !== ehs) || (gvs !== evs) || (gde !== ede)) begin
            $display("[FAIL] %0t: hsync/vsync/de %b%b%b at (%0d,%0d), expected %b%b%b",
                     $time, ghs, gvs, gde, ox, oy, ehs, evs, ede);
            abort_run();
        end
    endtask

    task automatic verify_center(input logic [coord_w-1:0] gx, input logic [coord_w-1:0] gy,
                                 input logic [coord_w-1:0] ex, input logic [coord_w-1:0] ey);
        if ((gx !== ex) || (gy !== ey)) begin
            $display("[FAIL] %0t: center (%0d,%0d), expected (%0d,%0d)", $time, gx, gy, ex, ey);
            abort_run();
        end
    endtask

    task automatic match_apb(input logic [apb_data_w-1:0] got, input logic [apb_data_w-1:0] exp,
                             input logic gerr, input logic eerr, input string what);
        if ((got !== exp) || (gerr !== eerr)) begin
            $display("[FAIL] %0t: %s data %h err %b, expected %h err %b",
                     $time, what, got, gerr, exp, eerr);
            abort_run();
        end
    endtask

    task automatic apb_access(input logic wr, input logic [apb_addr_w-1:0] addr,
                              input logic [apb_data_w-1:0] wdata,
                              output logic [apb_data_w-1:0] rdata, output logic err);
        @(negedge clk_pixel);
        psel = 1'b1;                                 // setup phase
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = wdata;
        @(negedge clk_pixel);
        penable = 1'b1;                              // access, completes at the next rise
        @(negedge clk_pixel);
        rdata = prdata;
        err = pslverr;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic wait_frame_start();
        do @(negedge clk_pixel); while ((hc != 0) || (vc != 0));
    endtask

    task automatic apply_config(input logic [chan_w-1:0] ch, input logic [mode_w-1:0] md,
                                input logic sc, input logic [7:0] lo, input logic [7:0] hi);
        logic [apb_data_w-1:0] rdata;
        logic                  err;
        cfg_channel = ch;
        cfg_mode = md;
        cfg_scale = sc;
        cfg_lower = lo;
        cfg_upper = hi;
        compute_expected_com();
        apb_access(1'b1, REG_CTRL, ctrl_word(), rdata, err);
        match_apb('0, '0, err, 1'b0, "REG_CTRL write");
        apb_access(1'b1, REG_THRESH, thresh_word(), rdata, err);
        match_apb('0, '0, err, 1'b0, "REG_THRESH write");
        wait_frame_start();                          // pending values go live here
        wait_frame_start();                          // first frame built only from them
        check_en = 1'b1;
        wait_frame_start();
        check_en = 1'b0;
        apb_access(1'b0, REG_CTRL, '0, rdata, err);
        match_apb(rdata, ctrl_word(), err, 1'b0, "REG_CTRL readback");
        apb_access(1'b0, REG_THRESH, '0, rdata, err);
        match_apb(rdata, thresh_word(), err, 1'b0, "REG_THRESH readback");
    endtask

    // output lags the counters by PIPE_DELAY cycles
    always @(negedge clk_pixel) begin
        int   pos, ox, oy;
        logic exp_de, exp_hs, exp_vs;
        if (check_en) begin
            pos = vc * h_total + hc - PIPE_DELAY;
            if (pos < 0) pos = pos + frame_cycles;
            ox = pos % h_total;
            oy = pos / h_total;
            exp_de = (ox < h_active) && (oy < v_active);
            exp_hs = (ox >= h_active + h_front) && (ox < h_active + h_front + h_sync);
            exp_vs = (oy >= v_active + v_front) && (oy < v_active + v_front + v_sync);
            inspect_timing(hsync, vsync, de, exp_hs, exp_vs, exp_de, ox, oy);
            if (exp_de) compare_pixel(pix_out, expected_pixel(ox, oy), ox, oy);
        end
    end

    initial begin
        #(run_frames * frame_cycles * clk_period);
        $display("watchdog expired before the tests finished");
        abort_run();
    end

    initial begin
        logic [apb_data_w-1:0] rdata;
        logic                  err;
        int                    n;
        recent_reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        fb_pixel = '0;
        check_en = 1'b0;
        exp_com_x = '0;
        exp_com_y = '0;
        n = $urandom(rng_seed);
        foreach (fb_mem[i]) fb_mem[i] = 24'($urandom);
        repeat (10) @(negedge clk_pixel);
        recent_reset = 1'b0;

        apply_config(CH_RED, MODE_CAMERA, 1'b0, 8'h00, 8'hFF);    // camera 1x
        apply_config(CH_RED, MODE_CAMERA, 1'b1, 8'h00, 8'hFF);    // camera 4x
        for (int ch = 0; ch < 4; ch++) begin
            apply_config(chan_w'(ch), MODE_CHANNEL, 1'b0, 8'h00, 8'hFF);
        end
        apply_config(CH_GREEN, MODE_MASK, 1'b0, 8'h40, 8'hBF);

        apply_config(CH_RED, MODE_MASK, 1'b0, 8'h30, 8'hA0);
        n = 0;
        do begin
            @(negedge clk_pixel);
            n++;
        end while (!com_valid && (n < frame_cycles));
        if (!com_valid) begin
            $display("com_valid did not pulse within a frame");
            abort_run();
        end
        verify_center(com_x, com_y, exp_com_x, exp_com_y);
        apb_access(1'b0, REG_COM, '0, rdata, err);
        match_apb(rdata, {exp_com_y, exp_com_x}, err, 1'b0, "REG_COM read");

        apply_config(CH_RED, MODE_CROSSHAIR, 1'b0, 8'h30, 8'hA0);  // same center as before

        apb_access(1'b1, 8'h0C, 32'hFFFF_FFFF, rdata, err);
        match_apb('0, '0, err, 1'b1, "write to unmapped address");
        apb_access(1'b0, 8'h20, '0, rdata, err);
        match_apb('0, '0, err, 1'b1, "read of unmapped address");  // error data undefined
        apb_access(1'b1, REG_COM, 32'h1234_5678, rdata, err);
        match_apb('0, '0, err, 1'b1, "write to REG_COM");
        wait_frame_start();
        wait_frame_start();                          // a stray write would be live by now
        apb_access(1'b0, REG_CTRL, '0, rdata, err);
        match_apb(rdata, ctrl_word(), err, 1'b0, "REG_CTRL after errors");
        apb_access(1'b0, REG_THRESH, '0, rdata, err);
        match_apb(rdata, thresh_word(), err, 1'b0, "REG_THRESH after errors");
        apb_access(1'b0, REG_COM, '0, rdata, err);
        match_apb(rdata, {exp_com_y, exp_com_x}, err, 1'b0, "REG_COM after errors");

        if (i_vision_top.i_vision_props.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/vision_props.sv
`default_nettype none

module vision_props (
    input wire                clk_pixel,
    input wire                recent_reset,
    input wire vision_pkg::pixel_t pix_out,
    input wire                hsync,
    input wire                vsync,
    input wire                de,
    input wire                com_valid,
    input wire                pready
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;    // assertion failures so far

    // blanking carries black
    blank_black: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        !de |-> (pix_out == '0))
        else begin fail_count++; $error("pix_out not zero while de is low"); end

    com_pulse: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        com_valid |=> !com_valid)    // single-cycle strobe
        else begin fail_count++; $error("com_valid held longer than one cycle"); end

    no_wait: assert property (@(posedge clk_pixel) pready)
        else begin fail_count++; $error("pready dropped"); end

    // sync reset, outputs quiet one cycle later
    reset_quiet: assert property (@(posedge clk_pixel)
        recent_reset |=> (!hsync && !vsync && !de))
        else begin fail_count++; $error("sync or de active during reset"); end

endmodule

bind vision_top vision_props i_vision_props (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .pix_out(pix_out),
    .hsync(hsync),
    .vsync(vsync),
    .de(de),
    .com_valid(com_valid),
    .pready(pready)
);

`default_nettype wire

// File: src/vision_top.sv
`default_nettype none

module vision_top #(
    parameter int  H_ACTIVE = 1280,
    parameter int  H_FRONT  = 110,
    parameter int  H_SYNC   = 40,
    parameter int  H_BACK   = 220,
    parameter int  V_ACTIVE = 720,
    parameter int  V_FRONT  = 5,
    parameter int  V_SYNC   = 5,
    parameter int  V_BACK   = 20,
    parameter int  FB_W     = 320,
    parameter int  FB_H     = 180,
    localparam int fb_addr_w = $clog2(FB_W * FB_H)
) (
    input  wire                               clk_pixel,
    input  wire                               recent_reset,
    input  wire                               psel,
    input  wire                               penable,
    input  wire                               pwrite,
    input  wire  [vision_pkg::apb_addr_w-1:0] paddr,
    input  wire  [vision_pkg::apb_data_w-1:0] pwdata,
    output logic [vision_pkg::apb_data_w-1:0] prdata,
    output logic                              pready,
    output logic                              pslverr,
    output logic [fb_addr_w-1:0]              fb_addr,
    output logic                              fb_valid,
    input  wire  vision_pkg::pixel_t          fb_pixel,  // one cycle after fb_addr
    output vision_pkg::pixel_t                pix_out,
    output logic                              hsync,
    output logic                              vsync,
    output logic                              de,
    output logic [vision_pkg::coord_w-1:0]    com_x,
    output logic [vision_pkg::coord_w-1:0]    com_y,
    output logic                              com_valid
);
    import vision_pkg::*;

    logic [coord_w-1:0] hcount, vcount, hcount_d, vcount_d;   // cycle 0 and mask-stage copies
    logic               new_frame, new_frame_d, hsync_d, vsync_d, active_d;
    logic [chan_w-1:0]  channel;
    logic [mode_w-1:0]  mode;
    logic               scale_4x, fb_valid_d, mask;
    logic [7:0]         lower, upper, chan_byte;
    pixel_t             pixel;

    video_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) i_video_timing (
        .clk_pixel, .recent_reset, .hcount, .vcount,
        .hsync(), .vsync(), .active(),          // only the delayed copies leave
        .new_frame, .hcount_d, .vcount_d, .hsync_d, .vsync_d, .active_d, .new_frame_d
    );

    vision_regs i_vision_regs (
        .clk_pixel, .recent_reset, .psel, .penable, .pwrite, .paddr, .pwdata,
        .new_frame, .com_x, .com_y, .prdata, .pready, .pslverr,
        .channel, .mode, .scale_4x, .lower, .upper
    );

    fb_address #(.FB_W(FB_W), .FB_H(FB_H)) i_fb_address (
        .clk_pixel, .hcount, .vcount, .scale_4x, .fb_addr, .fb_valid, .fb_valid_d
    );

    pixel_mask i_pixel_mask (
        .clk_pixel, .recent_reset, .fb_pixel, .fb_valid_d, .channel, .lower, .upper,
        .pixel, .chan_byte, .mask
    );

    center_of_mass i_center_of_mass (
        .clk_pixel, .recent_reset, .x(hcount_d), .y(vcount_d), .mask,
        .frame_end(new_frame_d), .com_x, .com_y, .com_valid
    );

    video_compose i_video_compose (
        .clk_pixel, .recent_reset, .pixel, .chan_byte, .mask, .mode,
        .hcount_d, .vcount_d, .com_x, .com_y, .hsync_d, .vsync_d, .active_d,
        .pix_out, .hsync_out(hsync), .vsync_out(vsync), .de
    );

endmodule

`default_nettype wire

// File: src/video_compose.sv
`default_nettype none

module video_compose (
    input  wire                            clk_pixel,
    input  wire                            recent_reset,
    input  wire  vision_pkg::pixel_t       pixel,
    input  wire  [7:0]                     chan_byte,
    input  wire                            mask,
    input  wire  [vision_pkg::mode_w-1:0]  mode,
    input  wire  [vision_pkg::coord_w-1:0] hcount_d,
    input  wire  [vision_pkg::coord_w-1:0] vcount_d,
    input  wire  [vision_pkg::coord_w-1:0] com_x,
    input  wire  [vision_pkg::coord_w-1:0] com_y,
    input  wire                            hsync_d,
    input  wire                            vsync_d,
    input  wire                            active_d,
    output vision_pkg::pixel_t             pix_out,
    output logic                           hsync_out,
    output logic                           vsync_out,
    output logic                           de
);
    import vision_pkg::*;

    pixel_t shade;
    logic   on_cross;

    assign on_cross = (hcount_d == com_x) || (vcount_d == com_y);  // column or row of the com

    always_comb begin
        shade = pixel;                      // camera view
        case (mode)
            MODE_CHANNEL: begin
                shade.rgb.red   = chan_byte;  // grayscale from one channel
                shade.rgb.green = chan_byte;
                shade.rgb.blue  = chan_byte;
            end
            MODE_MASK:      shade = mask ? '1 : '0;
            MODE_CROSSHAIR: shade = on_cross ? '1 : pixel;
            default:        shade = pixel;
        endcase
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            pix_out   <= '0;
            hsync_out <= 1'b0;
            vsync_out <= 1'b0;
            de        <= 1'b0;
        end else begin
            pix_out   <= active_d ? shade : '0;  // blank outside the active area
            hsync_out <= hsync_d;
            vsync_out <= vsync_d;
            de        <= active_d;
        end
    end

endmodule

`default_nettype wire

// File: tracker/center_of_mass.sv
`default_nettype none

module center_of_mass (
    input  wire                            clk_pixel,
    input  wire                            recent_reset,
    input  wire  [vision_pkg::coord_w-1:0] x,
    input  wire  [vision_pkg::coord_w-1:0] y,
    input  wire                            mask,
    input  wire                            frame_end,   // first pixel of the next frame
    output logic [vision_pkg::coord_w-1:0] com_x,
    output logic [vision_pkg::coord_w-1:0] com_y,
    output logic                           com_valid
);
    import vision_pkg::*;

    localparam int sum_w = 2 * coord_w;        // holds a full 1280x720 frame of sums
    localparam int step_w = $clog2(sum_w);

    logic [sum_w-1:0]   sum_x, sum_y, count;   // running totals for this frame
    logic [sum_w-1:0]   snap_y, divisor;       // last frame, kept while dividing
    logic [sum_w-1:0]   rem, quo, rem_next, quo_next;
    logic [sum_w:0]     trial;
    logic [step_w-1:0]  step;
    logic               busy, second;          // second: working on y
    logic [coord_w-1:0] res_x;

    // one restoring step: shift in the next dividend bit, subtract if it fits
    always_comb begin
        trial = {rem, quo[sum_w-1]};
        if (trial >= {1'b0, divisor}) begin
            rem_next = sum_w'(trial - {1'b0, divisor});
            quo_next = {quo[sum_w-2:0], 1'b1};
        end else begin
            rem_next = trial[sum_w-1:0];
            quo_next = {quo[sum_w-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            sum_x <= '0;
            sum_y <= '0;
            count <= '0;
        end else if (frame_end) begin
            sum_x <= mask ? sum_w'(x) : '0;     // restart with this pixel
            sum_y <= mask ? sum_w'(y) : '0;
            count <= sum_w'(mask);
        end else if (mask) begin
            sum_x <= sum_x + sum_w'(x);
            sum_y <= sum_y + sum_w'(y);
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            busy      <= 1'b0;
            second    <= 1'b0;
            step      <= '0;
            com_valid <= 1'b0;
            com_x     <= '0;
            com_y     <= '0;
        end else begin
            com_valid <= 1'b0;
            if (frame_end && (count != '0)) begin  // empty frame keeps the old center
                busy    <= 1'b1;
                second  <= 1'b0;
                step    <= '0;
                rem     <= '0;
                quo     <= sum_x;
                divisor <= count;
                snap_y  <= sum_y;
            end else if (busy) begin
                step <= step + 1'b1;
                rem  <= rem_next;
                quo  <= quo_next;
                if (step == step_w'(sum_w - 1)) begin
                    if (!second) begin
                        res_x  <= quo_next[coord_w-1:0];  // mean fits a coordinate
                        second <= 1'b1;
                        rem    <= '0;
                        quo    <= snap_y;
                    end else begin
                        busy      <= 1'b0;
                        com_valid <= 1'b1;
                        com_x     <= res_x;
                        com_y     <= quo_next[coord_w-1:0];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tracker/pixel_mask.sv
`default_nettype none

module pixel_mask (
    input  wire                            clk_pixel,
    input  wire                            recent_reset,
    input  wire  vision_pkg::pixel_t       fb_pixel,
    input  wire                            fb_valid_d,
    input  wire  [vision_pkg::chan_w-1:0]  channel,
    input  wire  [7:0]                     lower,
    input  wire  [7:0]                     upper,
    output vision_pkg::pixel_t             pixel,
    output logic [7:0]                     chan_byte,
    output logic                           mask
);
    import vision_pkg::*;

    pixel_t     pix_in;
    logic [7:0] sel;

    assign pix_in = fb_valid_d ? fb_pixel : '0;  // black outside the buffer

    // byte array view, code 3 has no channel
    assign sel = (channel > CH_RED) ? 8'h00 : pix_in.chan[channel];

    always_ff @(posedge clk_pixel) begin
        pixel     <= pix_in;
        chan_byte <= sel;
        if (recent_reset) begin
            mask <= 1'b0;
        end else begin
            mask <= fb_valid_d && (sel >= lower) && (sel <= upper);  // inclusive window
        end
    end

endmodule

`default_nettype wire

// File: src/fb_address.sv
`default_nettype none

module fb_address #(
    parameter int  FB_W = 320,
    parameter int  FB_H = 180,
    localparam int addr_w = $clog2(FB_W * FB_H)
) (
    input  wire                          clk_pixel,
    input  wire [vision_pkg::coord_w-1:0] hcount,
    input  wire [vision_pkg::coord_w-1:0] vcount,
    input  wire                          scale_4x,
    output logic [addr_w-1:0]            fb_addr,
    output logic                         fb_valid,
    output logic                         fb_valid_d    // lines up with the returned pixel
);
    import vision_pkg::*;

    logic [coord_w-1:0]   sx, sy;    // frame-buffer column and row
    logic [coord_w-1:0]   mx;        // column after the mirror
    logic [2*coord_w-1:0] linear;

    assign sx = scale_4x ? (hcount >> 2) : hcount;
    assign sy = scale_4x ? (vcount >> 2) : vcount;
    assign mx = coord_w'(FB_W - 1) - sx;  // wraps outside the buffer, masked by fb_valid
    assign linear = sy * coord_w'(FB_W) + mx;

    // registered like the address port of a block ram
    always_ff @(posedge clk_pixel) begin
        fb_addr    <= linear[addr_w-1:0];
        fb_valid   <= (sx < FB_W) && (sy < FB_H);
        fb_valid_d <= fb_valid;
    end

endmodule

`default_nettype wire

// File: src/vision_regs.sv
`default_nettype none

module vision_regs (
    input  wire                               clk_pixel,
    input  wire                               recent_reset,
    input  wire                               psel,
    input  wire                               penable,
    input  wire                               pwrite,
    input  wire  [vision_pkg::apb_addr_w-1:0] paddr,
    input  wire  [vision_pkg::apb_data_w-1:0] pwdata,
    input  wire                               new_frame,
    input  wire  [vision_pkg::coord_w-1:0]    com_x,
    input  wire  [vision_pkg::coord_w-1:0]    com_y,
    output logic [vision_pkg::apb_data_w-1:0] prdata,
    output logic                              pready,
    output logic                              pslverr,
    output logic [vision_pkg::chan_w-1:0]     channel,
    output logic [vision_pkg::mode_w-1:0]     mode,
    output logic                              scale_4x,
    output logic [7:0]                        lower,
    output logic [7:0]                        upper
);
    import vision_pkg::*;

    // values written over apb, waiting for the next frame
    logic [chan_w-1:0] pend_channel;
    logic [mode_w-1:0] pend_mode;
    logic              pend_scale;
    logic [7:0]        pend_lower, pend_upper;
    logic              access, mapped, wr_en;

    assign access = psel && penable;                      // access phase only
    assign mapped = (paddr == REG_CTRL) || (paddr == REG_THRESH) || (paddr == REG_COM);
    assign wr_en = access && pwrite && mapped && (paddr != REG_COM);
    assign pready = 1'b1;                                 // no wait states
    assign pslverr = access && (!mapped || (pwrite && (paddr == REG_COM)));

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            pend_channel <= '0;
            pend_mode    <= '0;
            pend_scale   <= 1'b0;
            pend_lower   <= 8'h00;
            pend_upper   <= 8'hFF;  // open window
        end else if (wr_en) begin
            if (paddr == REG_CTRL) begin
                pend_channel <= pwdata[1:0];
                pend_mode    <= pwdata[3:2];
                pend_scale   <= pwdata[4];
            end else begin
                pend_lower <= pwdata[7:0];
                pend_upper <= pwdata[15:8];
            end
        end
    end

    // live copy changes only at a frame boundary
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            channel  <= '0;
            mode     <= '0;
            scale_4x <= 1'b0;
            lower    <= 8'h00;
            upper    <= 8'hFF;
        end else if (new_frame) begin
            channel  <= pend_channel;
            mode     <= pend_mode;
            scale_4x <= pend_scale;
            lower    <= pend_lower;
            upper    <= pend_upper;
        end
    end

    always_comb begin
        case (paddr)
            REG_CTRL:   prdata = {{(apb_data_w - 5){1'b0}}, scale_4x, mode, channel};
            REG_THRESH: prdata = {{(apb_data_w - 16){1'b0}}, upper, lower};
            REG_COM:    prdata = {com_y, com_x};
            default:    prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/video_timing.sv
`default_nettype none

module video_timing #(
    parameter int H_ACTIVE = 1280,
    parameter int H_FRONT  = 110,
    parameter int H_SYNC   = 40,
    parameter int H_BACK   = 220,
    parameter int V_ACTIVE = 720,
    parameter int V_FRONT  = 5,
    parameter int V_SYNC   = 5,
    parameter int V_BACK   = 20
) (
    input  wire                            clk_pixel,
    input  wire                            recent_reset,
    output logic [vision_pkg::coord_w-1:0] hcount,
    output logic [vision_pkg::coord_w-1:0] vcount,
    output logic                           hsync,
    output logic                           vsync,
    output logic                           active,
    output logic                           new_frame,
    output logic [vision_pkg::coord_w-1:0] hcount_d,     // copies lined up with the mask stage
    output logic [vision_pkg::coord_w-1:0] vcount_d,
    output logic                           hsync_d,
    output logic                           vsync_d,
    output logic                           active_d,
    output logic                           new_frame_d
);
    import vision_pkg::*;

    localparam logic [coord_w-1:0] h_last = coord_w'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
    localparam logic [coord_w-1:0] v_last = coord_w'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);
    localparam int lag = PIPE_DELAY - 1;  // counters -> fb addr -> fb data -> mask

    logic [lag-1:0][coord_w-1:0] hc_pipe, vc_pipe;
    logic [lag-1:0]              hs_pipe, vs_pipe, act_pipe, nf_pipe;

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            hcount <= '0;
            vcount <= '0;
        end else if (hcount == h_last) begin
            hcount <= '0;
            vcount <= (vcount == v_last) ? '0 : vcount + 1'b1;  // wrap to top of screen
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    // sync pulses active high, counted from the end of the active area
    assign hsync = (hcount >= H_ACTIVE + H_FRONT) && (hcount < H_ACTIVE + H_FRONT + H_SYNC);
    assign vsync = (vcount >= V_ACTIVE + V_FRONT) && (vcount < V_ACTIVE + V_FRONT + V_SYNC);
    assign active = (hcount < H_ACTIVE) && (vcount < V_ACTIVE);
    assign new_frame = (hcount == '0) && (vcount == '0);  // one cycle at the origin

    always_ff @(posedge clk_pixel) begin
        hc_pipe <= {hc_pipe[lag-2:0], hcount};
        vc_pipe <= {vc_pipe[lag-2:0], vcount};
        if (recent_reset) begin
            hs_pipe  <= '0;
            vs_pipe  <= '0;
            act_pipe <= '0;
            nf_pipe  <= '0;
        end else begin
            hs_pipe  <= {hs_pipe[lag-2:0], hsync};
            vs_pipe  <= {vs_pipe[lag-2:0], vsync};
            act_pipe <= {act_pipe[lag-2:0], active};
            nf_pipe  <= {nf_pipe[lag-2:0], new_frame};
        end
    end

    assign hcount_d    = hc_pipe[lag-1];
    assign vcount_d    = vc_pipe[lag-1];
    assign hsync_d     = hs_pipe[lag-1];
    assign vsync_d     = vs_pipe[lag-1];
    assign active_d    = act_pipe[lag-1];
    assign new_frame_d = nf_pipe[lag-1];    // frame end seen by the com sums

endmodule

`default_nettype wire

// File: common/vision_pkg.sv
`default_nettype none

package vision_pkg;

    localparam int coord_w = 16;      // every screen and frame-buffer coordinate
    localparam int chan_w = 2;
    localparam int mode_w = 2;
    localparam int apb_addr_w = 8;
    localparam int apb_data_w = 32;

    // cycles from a counter value to its output pixel
    localparam int PIPE_DELAY = 4;

    // channel codes are the byte index into the pixel array view
    localparam logic [chan_w-1:0] CH_BLUE  = 2'd0;
    localparam logic [chan_w-1:0] CH_GREEN = 2'd1;
    localparam logic [chan_w-1:0] CH_RED   = 2'd2;  // code 3 selects a zero channel

    localparam logic [mode_w-1:0] MODE_CAMERA    = 2'd0;
    localparam logic [mode_w-1:0] MODE_CHANNEL   = 2'd1;
    localparam logic [mode_w-1:0] MODE_MASK      = 2'd2;
    localparam logic [mode_w-1:0] MODE_CROSSHAIR = 2'd3;

    // apb register map
    localparam logic [apb_addr_w-1:0] REG_CTRL   = 8'h00;  // channel, mode, scale_4x
    localparam logic [apb_addr_w-1:0] REG_THRESH = 8'h04;  // lower, upper
    localparam logic [apb_addr_w-1:0] REG_COM    = 8'h08;  // read only, com_y:com_x

    typedef struct packed {
        logic [7:0] red;    // top byte
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // same 24 bits, named colors or an array indexed by channel code
    typedef union packed {
        rgb_t            rgb;
        logic [2:0][7:0] chan;  // chan[2] red, chan[0] blue
    } pixel_t;

endpackage

`default_nettype wire
